//--- files.f
+incdir+include
rtl/mem_bus_pkg.sv
rtl/dcache_pkg.sv
rtl/dcache_req_decode.sv
rtl/dcache_way_store.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_line_merge.sv
rtl/dcache_top.sv
testbench/mem_model.sv
testbench/dcache_tb.sv

//--- Makefile
VERILATOR   = verilator
FILE_LIST   = files.f
TOP         = dcache_tb
LINT_TOP    = dcache_top
BUILD_FLAGS = --binary --timing -j 0
LINT_FLAGS  = --lint-only -Wall --timing
LOG         = sim.log
PASS_TEXT   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILE_LIST)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/dcache_tb.sv
`include "dcache_config.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_DELAY   = 4;
    localparam int N_FIXED     = 13;
    localparam int N_RAND      = 24;
    localparam int N_ENTRIES   = N_FIXED + N_RAND;
    // dirty writeback then refill at the longest ready delay
    localparam int MISS_CYCLES = 2 * (MAX_DELAY + 2) + 6;
    localparam int CYCLE_LIMIT = N_ENTRIES * MISS_CYCLES + 50;

    logic                         clk;
    logic                         reset;
    logic                         valid;
    dcache_pkg::op_e              op;
    logic [`ADDR_SIZE-1:0]        addr;
    logic [`WSTRB_SIZE-1:0]       wstrb;
    mem_bus_pkg::word_t           wdata;
    logic                         addr_ok;
    logic                         data_ok;
    mem_bus_pkg::word_t           rdata;
    logic                         rd_req;
    mem_bus_pkg::rd_type_e        rd_type;
    logic [`ADDR_SIZE-1:0]        rd_addr;
    logic                         rd_rdy;
    logic                         ret_valid;
    mem_bus_pkg::line_t           ret_data;
    logic                         wr_req;
    logic [`ADDR_SIZE-1:0]        wr_addr;
    logic [`WSTRB_SIZE-1:0]       wr_wstrb;
    mem_bus_pkg::line_t           wr_data;
    logic                         wr_rdy;

    // hit marks entries that must finish in one cycle
    dcache_pkg::op_e              t_op    [N_ENTRIES];
    logic [`ADDR_SIZE-1:0]        t_addr  [N_ENTRIES];
    logic [`WSTRB_SIZE-1:0]       t_wstrb [N_ENTRIES];
    mem_bus_pkg::word_t           t_wdata [N_ENTRIES];
    bit                           t_hit   [N_ENTRIES];

    mem_bus_pkg::word_t           shadow [logic [`ADDR_SIZE-1:0]];
    mem_bus_pkg::word_t           exp_q [$];
    bit                           load_q [$];
    bit                           hit_q [$];
    int                           acc_q [$];
    logic [`ADDR_SIZE-1:0]        addr_q [$];
    int                           cycle = 0;
    int                           wb_count = 0;
    bit                           after_hit = 1'b0;

    dcache_top u_dcache_top (.*);

    mem_model #(.MAX_DELAY(MAX_DELAY)) u_mem_model (
        .clk(clk), .reset(reset), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_data(ret_data), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "run stopped");
        end
    endtask

    function automatic mem_bus_pkg::word_t shadow_word(logic [`ADDR_SIZE-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    task automatic set_entry(input int i, input dcache_pkg::op_e o, input logic [31:0] a,
                             input logic [3:0] s, input logic [31:0] d, input bit h);
        t_op[i]    = o;
        t_addr[i]  = a;
        t_wstrb[i] = s;
        t_wdata[i] = d;
        t_hit[i]   = h;
    endtask

    task automatic fill_table();
        logic [31:0] a;
        // tags 1 2 3 in set 3 cycle through both ways
        set_entry(0,  dcache_pkg::op_load,  32'h0000_1064, 4'h0, 32'h0, 1'b0);
        set_entry(1,  dcache_pkg::op_load,  32'h0000_1068, 4'h0, 32'h0, 1'b1);
        set_entry(2,  dcache_pkg::op_store, 32'h0000_106c, 4'h3, 32'hdead_beef, 1'b1);
        set_entry(3,  dcache_pkg::op_load,  32'h0000_106c, 4'h0, 32'h0, 1'b1);
        set_entry(4,  dcache_pkg::op_store, 32'h0000_2070, 4'hc, 32'h1234_5678, 1'b0);
        set_entry(5,  dcache_pkg::op_load,  32'h0000_2070, 4'h0, 32'h0, 1'b1);
        set_entry(6,  dcache_pkg::op_load,  32'h0000_3060, 4'h0, 32'h0, 1'b0); // evicts tag 1
        set_entry(7,  dcache_pkg::op_load,  32'h0000_106c, 4'h0, 32'h0, 1'b0); // evicts tag 2
        set_entry(8,  dcache_pkg::op_load,  32'h0000_2070, 4'h0, 32'h0, 1'b0);
        set_entry(9,  dcache_pkg::op_load,  32'h0000_2074, 4'h0, 32'h0, 1'b1);
        set_entry(10, dcache_pkg::op_load,  32'h0000_1060, 4'h0, 32'h0, 1'b1);
        set_entry(11, dcache_pkg::op_load,  32'h0000_207c, 4'h0, 32'h0, 1'b1);
        set_entry(12, dcache_pkg::op_load,  32'h0000_1064, 4'h0, 32'h0, 1'b1);
        for (int i = N_FIXED; i < N_ENTRIES; i++) begin
            a = ((1 + $urandom % 4) << 12) | ((5 + $urandom % 2) << 5) | (($urandom % 8) << 2);
            set_entry(i, dcache_pkg::op_e'($urandom % 2), a, 4'($urandom % 16), $urandom, 1'b0);
        end
    endtask

    task automatic accept(input int i);
        logic [31:0] wa;
        mem_bus_pkg::word_t m;
        wa = {t_addr[i][31:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            m[8*k +: 8] = {8{t_wstrb[i][k]}};
        end
        if (t_op[i] == dcache_pkg::op_store) begin
            shadow[wa] = (t_wdata[i] & m) | (shadow_word(wa) & ~m);
        end
        exp_q.push_back(shadow_word(wa));
        load_q.push_back(t_op[i] == dcache_pkg::op_load);
        hit_q.push_back(t_hit[i]);
        acc_q.push_back(cycle);
        addr_q.push_back(t_addr[i]);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout, no completion within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "run stopped");
        end
    end

    // responses and bus transfers sampled mid-cycle
    always @(negedge clk) begin
        if (after_hit) begin
            check("rd_req after hit", rd_req, 0);
            check("wr_req after hit", wr_req, 0);
        end
        after_hit = 1'b0;
        if (!reset && data_ok) begin
            if (exp_q.size() == 0) begin
                report_failure("data_ok seen with no request outstanding");
            end else begin
                if (load_q[0]) check("rdata", rdata, exp_q[0]);
                if (hit_q[0]) begin
                    check("data_ok latency", cycle - acc_q[0], 1);
                    after_hit = 1'b1;
                end
                void'(exp_q.pop_front());
                void'(load_q.pop_front());
                void'(hit_q.pop_front());
                void'(acc_q.pop_front());
                void'(addr_q.pop_front());
            end
        end
        if (rd_req) begin
            if (addr_q.size() == 0) begin
                report_failure("rd_req raised with no request outstanding");
            end else begin
                check("rd_type", rd_type, mem_bus_pkg::rd_line);
                check("rd_addr", rd_addr, {addr_q[0][31:5], 5'b00000});
            end
        end
        if (wr_req && wr_rdy) begin
            if (addr_q.size() == 0) begin
                report_failure("wr_req raised with no request outstanding");
            end else begin
                wb_count++;
                check("wr_addr offset", wr_addr[4:0], 0);
                check("wr_addr index", wr_addr[11:5], addr_q[0][11:5]);
                check("wr_wstrb", wr_wstrb, 4'hf);
                for (int b = 0; b < `BANK_NUM; b++) begin
                    check("wr_data", wr_data[b*`DATA_SIZE +: `DATA_SIZE],
                          shadow_word(wr_addr + 4 * b));
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h77a6a675));
        reset = 1'b1;
        valid = 1'b0;
        op    = dcache_pkg::op_load;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        fill_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("addr_ok after reset", addr_ok, 0);
        check("data_ok after reset", data_ok, 0);
        check("rd_req after reset", rd_req, 0);
        check("wr_req after reset", wr_req, 0);
        @(posedge clk);
        for (int i = 0; i < N_ENTRIES; i++) begin
            valid <= 1'b1;
            op    <= t_op[i];
            addr  <= t_addr[i];
            wstrb <= t_wstrb[i];
            wdata <= t_wdata[i];
            @(negedge clk);
            while (!addr_ok) @(negedge clk);
            accept(i);
            @(posedge clk); // transfer edge
        end
        valid <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        check("dirty writebacks", wb_count >= 2, 1);
        repeat (2) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- testbench/mem_model.sv
`include "dcache_config.svh"

module mem_model #(
    parameter int MAX_DELAY = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_req,
    input  logic [`ADDR_SIZE-1:0] rd_addr,
    output logic                  rd_rdy = 1'b0,
    output logic                  ret_valid = 1'b0,
    output mem_bus_pkg::line_t    ret_data = '0,
    input  logic                  wr_req,
    input  logic [`ADDR_SIZE-1:0] wr_addr,
    input  mem_bus_pkg::line_t    wr_data,
    output logic                  wr_rdy = 1'b0
);
    timeunit 1ns;
    timeprecision 1ps;

    mem_bus_pkg::word_t mem [logic [`ADDR_SIZE-1:0]]; // written-back words only
    int rd_wait;
    int wr_wait;

    // never written words follow the address rule
    function automatic mem_bus_pkg::word_t read_word(logic [`ADDR_SIZE-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            rd_wait   <= 0;
            wr_wait   <= 0;
        end else begin
            ret_valid <= 1'b0;
            if (rd_req && rd_rdy) begin
                rd_rdy    <= 1'b0;
                rd_wait   <= $urandom % (MAX_DELAY + 1);
                ret_valid <= 1'b1; // whole line one cycle after the transfer
                for (int b = 0; b < `BANK_NUM; b++) begin
                    ret_data[b*`DATA_SIZE +: `DATA_SIZE] <= read_word(rd_addr + 4 * b);
                end
            end else if (rd_req) begin
                if (rd_wait == 0) begin
                    rd_rdy <= 1'b1;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            if (wr_req && wr_rdy) begin
                wr_rdy  <= 1'b0;
                wr_wait <= $urandom % (MAX_DELAY + 1);
                for (int b = 0; b < `BANK_NUM; b++) begin
                    mem[wr_addr + 4 * b] = wr_data[b*`DATA_SIZE +: `DATA_SIZE];
                end
            end else if (wr_req) begin
                if (wr_wait == 0) begin
                    wr_rdy <= 1'b1;
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end
        end
    end

endmodule

//--- rtl/dcache_top.sv
`include "dcache_config.svh"

module dcache_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         valid,
    input  dcache_pkg::op_e              op,
    input  logic [`ADDR_SIZE-1:0]        addr,
    input  logic [`WSTRB_SIZE-1:0]       wstrb,
    input  mem_bus_pkg::word_t           wdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    output mem_bus_pkg::word_t           rdata,
    output logic                         rd_req,
    output mem_bus_pkg::rd_type_e        rd_type,
    output logic [`ADDR_SIZE-1:0]        rd_addr,
    input  logic                         rd_rdy,
    input  logic                         ret_valid,
    input  mem_bus_pkg::line_t           ret_data,
    output logic                         wr_req,
    output logic [`ADDR_SIZE-1:0]        wr_addr,
    output logic [`WSTRB_SIZE-1:0]       wr_wstrb,
    output mem_bus_pkg::line_t           wr_data,
    input  logic                         wr_rdy
);

    logic                   stall;
    logic                   req_valid;
    dcache_pkg::op_e        req_op;
    logic [`TAG_SIZE-1:0]   req_tag;
    logic [`INDEX_SIZE-1:0] req_index;
    logic [`BANK_BITS-1:0]  req_bank;
    logic [`WSTRB_SIZE-1:0] req_wstrb;
    mem_bus_pkg::word_t     req_wdata;
    logic [`INDEX_SIZE-1:0] rd_index;
    logic [`TAGV_SIZE-1:0]  tag_valid0;
    logic [`TAGV_SIZE-1:0]  tag_valid1;
    mem_bus_pkg::line_t     line0;
    mem_bus_pkg::line_t     line1;
    mem_bus_pkg::line_t     fill_line;
    logic                   hit;
    logic                   hit_way;
    logic                   refill_now;
    logic                   store_now;
    logic                   way_wr_en0;
    logic                   way_wr_en1;
    logic [`BANK_NUM-1:0]   wr_bank_mask;

    dcache_req_decode u_req_decode (
        .clk(clk), .reset(reset), .valid(valid), .op(op), .addr(addr),
        .wstrb(wstrb), .wdata(wdata), .stall(stall), .addr_ok(addr_ok),
        .req_valid(req_valid), .req_op(req_op), .req_tag(req_tag),
        .req_index(req_index), .req_bank(req_bank), .req_wstrb(req_wstrb),
        .req_wdata(req_wdata), .rd_index(rd_index)
    );

    dcache_way_store u_way0 (
        .clk(clk), .reset(reset), .rd_index(rd_index), .wr_en(way_wr_en0),
        .wr_index(req_index), .wr_tag(req_tag), .wr_bank_mask(wr_bank_mask),
        .wr_line(fill_line), .tag_valid(tag_valid0), .line(line0)
    );

    dcache_way_store u_way1 (
        .clk(clk), .reset(reset), .rd_index(rd_index), .wr_en(way_wr_en1),
        .wr_index(req_index), .wr_tag(req_tag), .wr_bank_mask(wr_bank_mask),
        .wr_line(fill_line), .tag_valid(tag_valid1), .line(line1)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_op(req_op),
        .req_tag(req_tag), .req_index(req_index), .req_bank(req_bank),
        .tag_valid0(tag_valid0), .tag_valid1(tag_valid1),
        .line0(line0), .line1(line1),
        .rd_rdy(rd_rdy), .wr_rdy(wr_rdy), .ret_valid(ret_valid),
        .stall(stall), .hit(hit), .hit_way(hit_way), .fill_way(),
        .refill_now(refill_now), .store_now(store_now),
        .way_wr_en0(way_wr_en0), .way_wr_en1(way_wr_en1), .wr_bank_mask(wr_bank_mask),
        .rd_req(rd_req), .rd_type(rd_type), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_wstrb(wr_wstrb), .wr_data(wr_data)
    );

    dcache_line_merge u_line_merge (
        .clk(clk), .reset(reset), .req_op(req_op), .req_bank(req_bank),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata),
        .line0(line0), .line1(line1), .ret_data(ret_data),
        .hit(hit), .hit_way(hit_way), .refill_now(refill_now), .store_now(store_now),
        .fill_line(fill_line), .rdata(rdata), .data_ok(data_ok)
    );

endmodule

//--- rtl/dcache_line_merge.sv
`include "dcache_config.svh"

module dcache_line_merge (
    input  logic                     clk,
    input  logic                     reset,
    input  dcache_pkg::op_e          req_op,
    input  logic [`BANK_BITS-1:0]    req_bank,
    input  logic [`WSTRB_SIZE-1:0]   req_wstrb,
    input  mem_bus_pkg::word_t       req_wdata,
    input  mem_bus_pkg::line_t       line0,
    input  mem_bus_pkg::line_t       line1,
    input  mem_bus_pkg::line_t       ret_data,
    input  logic                     hit,
    input  logic                     hit_way,
    input  logic                     refill_now,
    input  logic                     store_now,
    output mem_bus_pkg::line_t       fill_line,
    output mem_bus_pkg::word_t       rdata,
    output logic                     data_ok
);

    mem_bus_pkg::line_t base_line;
    mem_bus_pkg::word_t old_word;
    mem_bus_pkg::word_t new_word;
    mem_bus_pkg::word_t byte_mask;
    mem_bus_pkg::word_t rdata_q;
    logic               done_q;     // miss finished last cycle
    logic               merge;

    assign base_line = refill_now ? ret_data : (hit_way ? line1 : line0);
    assign old_word  = base_line[req_bank*`DATA_SIZE +: `DATA_SIZE];

    always_comb begin
        for (int i = 0; i < `WSTRB_SIZE; i++) begin
            byte_mask[8*i +: 8] = {8{req_wstrb[i]}};
        end
    end

    assign new_word = (req_wdata & byte_mask) | (old_word & ~byte_mask);
    assign merge    = store_now || (refill_now && req_op == dcache_pkg::op_store);

    always_comb begin
        fill_line = base_line;
        if (merge) begin
            fill_line[req_bank*`DATA_SIZE +: `DATA_SIZE] = new_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= refill_now;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_now) begin
            rdata_q <= old_word; // requested bank of the returned line
        end
    end

    assign data_ok = hit || done_q;
    assign rdata   = done_q ? rdata_q : old_word;

endmodule

//--- rtl/dcache_miss_ctrl.sv
`include "dcache_config.svh"

module dcache_miss_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  dcache_pkg::op_e              req_op,
    input  logic [`TAG_SIZE-1:0]         req_tag,
    input  logic [`INDEX_SIZE-1:0]       req_index,
    input  logic [`BANK_BITS-1:0]        req_bank,
    input  logic [`TAGV_SIZE-1:0]        tag_valid0,
    input  logic [`TAGV_SIZE-1:0]        tag_valid1,
    input  mem_bus_pkg::line_t           line0,
    input  mem_bus_pkg::line_t           line1,
    input  logic                         rd_rdy,
    input  logic                         wr_rdy,
    input  logic                         ret_valid,
    output logic                         stall,
    output logic                         hit,
    output logic                         hit_way,
    output logic                         fill_way,
    output logic                         refill_now,
    output logic                         store_now,
    output logic                         way_wr_en0,
    output logic                         way_wr_en1,
    output logic [`BANK_NUM-1:0]         wr_bank_mask,
    output logic                         rd_req,
    output mem_bus_pkg::rd_type_e        rd_type,
    output logic [`ADDR_SIZE-1:0]        rd_addr,
    output logic                         wr_req,
    output logic [`ADDR_SIZE-1:0]        wr_addr,
    output logic [`WSTRB_SIZE-1:0]       wr_wstrb,
    output mem_bus_pkg::line_t           wr_data
);

    dcache_pkg::state_e   state;
    dcache_pkg::state_e   state_next;
    logic [`SET_SIZE-1:0] lru;      // way used last, victim is the other one
    logic [`SET_SIZE-1:0] dirty0;
    logic [`SET_SIZE-1:0] dirty1;
    logic                 hit0;
    logic                 hit1;
    logic                 victim_dirty;
    logic [`TAG_SIZE-1:0] victim_tag;

    assign hit0 = tag_valid0[`TAG_SIZE] && tag_valid0[`TAG_SIZE-1:0] == req_tag;
    assign hit1 = tag_valid1[`TAG_SIZE] && tag_valid1[`TAG_SIZE-1:0] == req_tag;

    assign hit        = state == dcache_pkg::lookup && req_valid && (hit0 || hit1);
    assign hit_way    = hit1;
    assign store_now  = hit && req_op == dcache_pkg::op_store;
    assign refill_now = state == dcache_pkg::refill_wait && ret_valid;

    assign fill_way     = ~lru[req_index];
    assign victim_dirty = fill_way ? dirty1[req_index] : dirty0[req_index];
    assign victim_tag   = fill_way ? tag_valid1[`TAG_SIZE-1:0] : tag_valid0[`TAG_SIZE-1:0];

    assign way_wr_en0   = (store_now && !hit_way) || (refill_now && !fill_way);
    assign way_wr_en1   = (store_now && hit_way) || (refill_now && fill_way);
    assign wr_bank_mask = refill_now ? {`BANK_NUM{1'b1}}
                                     : {{(`BANK_NUM-1){1'b0}}, 1'b1} << req_bank;

    always_comb begin
        stall      = 1'b1;
        state_next = state;
        case (state)
            dcache_pkg::lookup: begin
                stall = req_valid && (!(hit0 || hit1) || req_op == dcache_pkg::op_store);
                if (req_valid && !(hit0 || hit1)) begin
                    state_next = victim_dirty ? dcache_pkg::writeback : dcache_pkg::refill_req;
                end else if (store_now) begin
                    state_next = dcache_pkg::store_commit;
                end
            end
            dcache_pkg::writeback: if (wr_rdy) state_next = dcache_pkg::refill_req;
            dcache_pkg::refill_req: if (rd_rdy) state_next = dcache_pkg::refill_wait;
            dcache_pkg::refill_wait: if (ret_valid) state_next = dcache_pkg::store_commit;
            default: begin
                stall      = 1'b0; // request retires, next one may enter
                state_next = dcache_pkg::lookup;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= dcache_pkg::lookup;
            lru    <= '0;
            dirty0 <= '0;
            dirty1 <= '0;
        end else begin
            state <= state_next;
            if (hit || refill_now) begin
                lru[req_index] <= refill_now ? fill_way : hit_way;
            end
            // refill of a load leaves the line clean
            if (way_wr_en0) dirty0[req_index] <= req_op == dcache_pkg::op_store;
            if (way_wr_en1) dirty1[req_index] <= req_op == dcache_pkg::op_store;
        end
    end

    // bus requests held by the state until accepted
    assign wr_req   = state == dcache_pkg::writeback;
    assign wr_addr  = {victim_tag, req_index, {`OFFSET_SIZE{1'b0}}};
    assign wr_wstrb = {`WSTRB_SIZE{1'b1}};
    assign wr_data  = fill_way ? line1 : line0;
    assign rd_req   = state == dcache_pkg::refill_req;
    assign rd_type  = mem_bus_pkg::rd_line;
    assign rd_addr  = {req_tag, req_index, {`OFFSET_SIZE{1'b0}}};

endmodule

//--- rtl/dcache_way_store.sv
`include "dcache_config.svh"

module dcache_way_store (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`INDEX_SIZE-1:0]   rd_index,
    input  logic                     wr_en,
    input  logic [`INDEX_SIZE-1:0]   wr_index,
    input  logic [`TAG_SIZE-1:0]     wr_tag,
    input  logic [`BANK_NUM-1:0]     wr_bank_mask,
    input  mem_bus_pkg::line_t       wr_line,
    output logic [`TAGV_SIZE-1:0]    tag_valid,
    output mem_bus_pkg::line_t       line
);

    logic [`TAG_SIZE-1:0] tag_mem [`SET_SIZE];
    logic [`SET_SIZE-1:0] valid;
    logic [`TAG_SIZE-1:0] tag_rd;
    logic                 valid_rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= '0;
            valid_rd <= 1'b0;
        end else begin
            if (wr_en) begin
                valid[wr_index] <= 1'b1;
            end
            valid_rd <= valid[rd_index]; // old value on a same-set write
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag; // unchanged tag on a store hit
        end
        tag_rd <= tag_mem[rd_index];
    end

    // one array per bank so a store touches a single bank
    for (genvar b = 0; b < `BANK_NUM; b++) begin : g_bank
        mem_bus_pkg::word_t bank_mem [`SET_SIZE];

        always_ff @(posedge clk) begin
            if (wr_en && wr_bank_mask[b]) begin
                bank_mem[wr_index] <= wr_line[b*`DATA_SIZE +: `DATA_SIZE];
            end
            line[b*`DATA_SIZE +: `DATA_SIZE] <= bank_mem[rd_index];
        end
    end

    assign tag_valid = {valid_rd, tag_rd};

endmodule

//--- rtl/dcache_req_decode.sv
`include "dcache_config.svh"

module dcache_req_decode (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  dcache_pkg::op_e          op,
    input  logic [`ADDR_SIZE-1:0]    addr,
    input  logic [`WSTRB_SIZE-1:0]   wstrb,
    input  mem_bus_pkg::word_t       wdata,
    input  logic                     stall,
    output logic                     addr_ok,
    output logic                     req_valid,
    output dcache_pkg::op_e          req_op,
    output logic [`TAG_SIZE-1:0]     req_tag,
    output logic [`INDEX_SIZE-1:0]   req_index,
    output logic [`BANK_BITS-1:0]    req_bank,
    output logic [`WSTRB_SIZE-1:0]   req_wstrb,
    output mem_bus_pkg::word_t       req_wdata,
    output logic [`INDEX_SIZE-1:0]   rd_index
);

    logic ready; // low through reset and the first cycle after it

    always_ff @(posedge clk) begin
        if (reset) begin
            ready     <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            ready <= 1'b1;
            if (!stall) begin
                req_valid <= valid && addr_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            req_op    <= op;
            req_tag   <= addr[`ADDR_SIZE-1 -: `TAG_SIZE];
            req_index <= addr[`OFFSET_SIZE +: `INDEX_SIZE];
            req_bank  <= addr[`BYTE_BITS +: `BANK_BITS];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    assign addr_ok  = ready && !stall;
    // keep the way read on the held set while stalled
    assign rd_index = stall ? req_index : addr[`OFFSET_SIZE +: `INDEX_SIZE];

endmodule

//--- rtl/dcache_pkg.sv
package dcache_pkg;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } op_e;

    // miss handling sequence of the controller
    typedef enum logic [2:0] {
        lookup,
        writeback,      // dirty victim out
        refill_req,
        refill_wait,
        store_commit    // retire cycle after a way write
    } state_e;

endpackage

//--- rtl/mem_bus_pkg.sv
`include "dcache_config.svh"

package mem_bus_pkg;

    typedef logic [`DATA_SIZE-1:0] word_t;

    // bank 0 sits in the low word
    typedef logic [`BANK_NUM*`DATA_SIZE-1:0] line_t;

    // read size on the bus, only rd_line is issued by the cache
    typedef enum logic [2:0] {
        rd_byte = 3'b000,
        rd_half = 3'b001,
        rd_word = 3'b010,
        rd_line = 3'b100
    } rd_type_e;

endpackage

//--- include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address and word
`define ADDR_SIZE 32
`define DATA_SIZE 32

// address fields, tag | index | offset
`define TAG_SIZE 20
`define INDEX_SIZE 7
`define OFFSET_SIZE 5

// byte offset within a word, bank select above it
`define BYTE_BITS 2
`define BANK_BITS 3
`define WSTRB_SIZE 4

// geometry
`define BANK_NUM 8
`define SET_SIZE 128

`define TAGV_SIZE 21 // valid on top of tag

`endif
